// File: ea_cfg_pkg.sv
package ea_cfg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Datapath widths
	////////////////////////////////////////////////////////////////////////////

	// Address bus and 16-bit data word
	localparam int ADR_W = 16;
	// Register and index width
	localparam int BYTE_W = 8;

	////////////////////////////////////////////////////////////////////////////
	// Stack and reset values
	////////////////////////////////////////////////////////////////////////////

	// High byte of every stack access
	localparam logic [BYTE_W-1:0] STACK_PAGE = 8'h01;
	// SP value out of reset, stack grows down from top of page
	localparam logic [BYTE_W-1:0] SP_START = 8'hFF;
	// Jump target out of reset
	localparam logic [ADR_W-1:0] PC_START = 16'h0000;

	////////////////////////////////////////////////////////////////////////////
	// Write history and hazard wait
	////////////////////////////////////////////////////////////////////////////

	// Writes still in flight behind this stage
	localparam int HIST_DEPTH = 3;
	// Byte count per write, 0 marks an empty slot
	localparam int CNT_W = 2;
	// Bubble count width
	localparam int WAIT_W = 2;

endpackage

// File: ea_isa_pkg.sv
package ea_isa_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Decoded control encodings
	////////////////////////////////////////////////////////////////////////////

	// Address mode
	// Direct is operand plus idx1
	// Indirect reads a pointer at operand plus idx1, then adds idx2
	// Stack takes the address from the SP unit
	typedef enum logic [1:0] {
		MODE_DIR   = 2'd0,
		MODE_INDIR = 2'd1,
		MODE_STACK = 2'd2
	} adr_mode_e;

	// Index register select, none adds zero
	typedef enum logic [1:0] {
		IDX_NONE = 2'd0,
		IDX_X    = 2'd1,
		IDX_Y    = 2'd2
	} idx_sel_e;

	// Stack operation, all accesses in the stack page
	typedef enum logic [2:0] {
		SOP_NONE    = 3'd0,
		SOP_PUSH    = 3'd1,
		SOP_PC_PUSH = 3'd2,
		SOP_POP     = 3'd3,
		SOP_PC_POP  = 3'd4,
		SOP_LOAD_X  = 3'd5
	} stack_op_e;

endpackage

// File: ea_adr_calc.sv
`timescale 1ns/1ns

module ea_adr_calc
	import ea_cfg_pkg::*;
	import ea_isa_pkg::*;
(
	input  adr_mode_e        mode_i,
	input  idx_sel_e         idx1_i,
	input  idx_sel_e         idx2_i,
	input  logic [BYTE_W-1:0] x_i,
	input  logic [BYTE_W-1:0] y_i,
	input  logic [ADR_W-1:0] operand_i,
	input  logic [ADR_W-1:0] mem_dat_i,
	input  logic [ADR_W-1:0] stack_adr_i,
	output logic [ADR_W-1:0] ptr_adr_o,
	output logic [ADR_W-1:0] eff_adr_o
);

	// Zero-extended index values
	logic [ADR_W-1:0] idx1_ext;
	logic [ADR_W-1:0] idx2_ext;
	// Pointer word plus second index
	logic [ADR_W-1:0] indir_sum;

	// Index mux shared by both offset adders
	function automatic logic [ADR_W-1:0] idx_value(
		input idx_sel_e          sel,
		input logic [BYTE_W-1:0] x,
		input logic [BYTE_W-1:0] y
	);
		logic [BYTE_W-1:0] val;
		case (sel)
			IDX_X:   val = x;
			IDX_Y:   val = y;
			default: val = '0;
		endcase
		// Index is unsigned, no sign extension
		return {{(ADR_W-BYTE_W){1'b0}}, val};
	endfunction

	assign idx1_ext = idx_value(idx1_i, x_i, y_i);
	assign idx2_ext = idx_value(idx2_i, x_i, y_i);

	// First offset
	// Direct address, or pointer location in indirect mode
	assign ptr_adr_o = operand_i + idx1_ext;

	// Pointer word comes back from memory in this same cycle
	assign indir_sum = mem_dat_i + idx2_ext;

	always_comb
	begin
		case (mode_i)
			MODE_INDIR: eff_adr_o = indir_sum;
			// Stack unit already resolved page and offset
			MODE_STACK: eff_adr_o = stack_adr_i;
			default:    eff_adr_o = ptr_adr_o;
		endcase
	end

endmodule

// File: ea_stack_ptr.sv
`timescale 1ns/1ns

module ea_stack_ptr
	import ea_cfg_pkg::*;
	import ea_isa_pkg::*;
(
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              issue_i,
	input  stack_op_e         stack_op_i,
	input  logic [BYTE_W-1:0] x_i,
	output logic [ADR_W-1:0]  stack_adr_o,
	output logic [ADR_W-1:0]  pop_adr_o,
	output logic [CNT_W-1:0]  push_cnt_o
);

	// Stack pointer, offset within the stack page
	logic [BYTE_W-1:0] sp_q;

	////////////////////////////////////////////////////////////////////////////
	// SP update, one edge after issue
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			sp_q <= SP_START;
		end
		else if (issue_i)
		begin
			case (stack_op_i)
				SOP_PUSH:    sp_q <= sp_q - 8'd1;
				SOP_PC_PUSH: sp_q <= sp_q - 8'd2;
				SOP_POP:     sp_q <= sp_q + 8'd1;
				SOP_PC_POP:  sp_q <= sp_q + 8'd2;
				SOP_LOAD_X:  sp_q <= x_i;
				default:     sp_q <= sp_q;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Access address and push size
	////////////////////////////////////////////////////////////////////////////

	// Pops read the slot above SP, both bytes for PC pop
	assign pop_adr_o = {STACK_PAGE, sp_q + 8'd1};

	always_comb
	begin
		case (stack_op_i)
			// Two-byte PC lands at SP-1 and SP
			SOP_PC_PUSH: stack_adr_o = {STACK_PAGE, sp_q - 8'd1};
			SOP_POP:     stack_adr_o = pop_adr_o;
			SOP_PC_POP:  stack_adr_o = pop_adr_o;
			default:     stack_adr_o = {STACK_PAGE, sp_q};
		endcase
	end

	// Bytes written by a push, zero for everything else
	assign push_cnt_o = (stack_op_i == SOP_PUSH)    ? CNT_W'(1) :
	                    (stack_op_i == SOP_PC_PUSH) ? CNT_W'(2) : '0;

	// SP only moves on an edge where the hazard unit granted issue
	a_sp_needs_issue: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		($past(rst_n_i) && !$past(issue_i)) |-> $stable(sp_q));

endmodule

// File: ea_wr_history.sv
`timescale 1ns/1ns

module ea_wr_history
	import ea_cfg_pkg::*;
(
	input  logic             clk_i,
	input  logic             rst_n_i,
	input  logic             shift_i,
	input  logic             wr_vld_i,
	input  logic [ADR_W-1:0] wr_adr_i,
	input  logic [CNT_W-1:0] wr_cnt_i,
	output logic [ADR_W-1:0] slot_adr_o [HIST_DEPTH],
	output logic [CNT_W-1:0] slot_cnt_o [HIST_DEPTH]
);

	// Index 0 is the newest write
	logic [ADR_W-1:0] adr_q [HIST_DEPTH];
	logic [CNT_W-1:0] cnt_q [HIST_DEPTH];

	// Destination addresses, meaningless while the count is zero
	always_ff @(posedge clk_i)
	begin
		if (shift_i)
		begin
			adr_q[0] <= wr_adr_i;
			for (int k = 1; k < HIST_DEPTH; k++)
			begin
				adr_q[k] <= adr_q[k-1];
			end
		end
	end

	// Byte counts double as slot valid
	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			for (int k = 0; k < HIST_DEPTH; k++)
			begin
				cnt_q[k] <= '0;
			end
		end
		else if (shift_i)
		begin
			// Bubble or non-writing instruction shifts in an empty slot
			cnt_q[0] <= wr_vld_i ? wr_cnt_i : '0;
			for (int k = 1; k < HIST_DEPTH; k++)
			begin
				cnt_q[k] <= cnt_q[k-1];
			end
		end
	end

	assign slot_adr_o = adr_q;
	assign slot_cnt_o = cnt_q;

	// A recorded write must occupy its slot, or hazards on it go unseen
	a_wr_slot_filled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(shift_i && wr_vld_i) |=> (cnt_q[0] != '0));

endmodule

// File: ea_hazard.sv
`timescale 1ns/1ns

module ea_hazard
	import ea_cfg_pkg::*;
(
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              hold_i,
	input  logic              valid_i,
	input  logic              indir_i,
	input  logic              rd_i,
	input  logic [ADR_W-1:0]  ptr_adr_i,
	input  logic [ADR_W-1:0]  eff_adr_i,
	input  logic [ADR_W-1:0]  slot_adr_i [HIST_DEPTH],
	input  logic [CNT_W-1:0]  slot_cnt_i [HIST_DEPTH],
	output logic [WAIT_W-1:0] wait_o,
	output logic              fwd_o,
	output logic              issue_o
);

	// Remaining bubbles after the detecting cycle
	logic [WAIT_W-1:0] cnt_q;
	// Worst wait over all slots, before gating
	logic [WAIT_W-1:0] hz_wait;
	// Wait that this instruction actually raises
	logic [WAIT_W-1:0] new_wait;
	// Data span hits the newest write
	logic              fwd_hit;

	// Two byte spans overlap modulo 64K so a wrap at 0xFFFF still counts
	function automatic logic span_hit(
		input logic [ADR_W-1:0] rd_adr,
		input logic [CNT_W-1:0] rd_cnt,
		input logic [ADR_W-1:0] wr_adr,
		input logic [CNT_W-1:0] wr_cnt
	);
		logic [ADR_W-1:0] d_rw;
		logic [ADR_W-1:0] d_wr;
		d_rw = rd_adr - wr_adr;
		d_wr = wr_adr - rd_adr;
		// Empty slot never hits
		return (wr_cnt != '0) &&
		       ((d_rw < {{(ADR_W-CNT_W){1'b0}}, wr_cnt}) ||
		        (d_wr < {{(ADR_W-CNT_W){1'b0}}, rd_cnt}));
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Overlap compares against each in-flight write
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		logic [WAIT_W-1:0] k_wait;
		hz_wait = '0;
		fwd_hit = 1'b0;
		k_wait  = '0;
		for (int k = 0; k < HIST_DEPTH; k++)
		begin
			// Older slots need fewer cycles until the write lands
			k_wait = WAIT_W'(HIST_DEPTH - k);
			// Two-byte pointer word
			if (indir_i && span_hit(ptr_adr_i, CNT_W'(2), slot_adr_i[k], slot_cnt_i[k]))
			begin
				if (k_wait > hz_wait)
					hz_wait = k_wait;
			end
			// Data byte at the final address
			if (rd_i && span_hit(eff_adr_i, CNT_W'(1), slot_adr_i[k], slot_cnt_i[k]))
			begin
				// Newest write is taken from the EX forward path
				if (k == 0)
					fwd_hit = 1'b1;
				else if (k_wait > hz_wait)
					hz_wait = k_wait;
			end
		end
	end

	// Fresh hazard only when the counter has drained
	assign new_wait = (valid_i && cnt_q == '0) ? hz_wait : '0;

	// Running count wins over a fresh hazard
	assign wait_o  = (cnt_q != '0) ? cnt_q : new_wait;
	assign fwd_o   = valid_i && fwd_hit;
	assign issue_o = rst_n_i && !hold_i && valid_i && (cnt_q == '0) && (hz_wait == '0);

	////////////////////////////////////////////////////////////////////////////
	// Wait counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			cnt_q <= '0;
		end
		else if (!hold_i)
		begin
			if (cnt_q != '0)
				cnt_q <= cnt_q - 1'b1;
			// Detecting cycle is the first bubble
			else if (new_wait != '0)
				cnt_q <= new_wait - 1'b1;
		end
	end

	// Upstream keeps the same instruction while a wait is shown
	a_hold_while_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(valid_i && wait_o != '0) |=> (valid_i && $stable(ptr_adr_i)));

endmodule

// File: ea_stage.sv
`timescale 1ns/1ns

module ea_stage
	import ea_cfg_pkg::*;
	import ea_isa_pkg::*;
(
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              stall_i,
	input  logic              valid_i,
	input  adr_mode_e         mode_i,
	input  idx_sel_e          idx1_i,
	input  idx_sel_e          idx2_i,
	input  stack_op_e         stack_op_i,
	input  logic              wr_i,
	input  logic [CNT_W-1:0]  wr_cnt_i,
	input  logic              rd_i,
	input  logic              jmp_i,
	input  logic [BYTE_W-1:0] x_i,
	input  logic [BYTE_W-1:0] y_i,
	input  logic [ADR_W-1:0]  operand_i,
	input  logic [ADR_W-1:0]  pc_i,
	input  logic [ADR_W-1:0]  mem_dat_i,
	output logic [ADR_W-1:0]  mem_adr_o,
	output logic [WAIT_W-1:0] wait_o,
	output logic              valid_o,
	output logic [ADR_W-1:0]  eff_adr_o,
	output logic [ADR_W-1:0]  dat_o,
	output logic              wr_o,
	output logic [CNT_W-1:0]  wr_cnt_o,
	output logic              fwd_o,
	output logic              refill_o,
	output logic [ADR_W-1:0]  jmp_adr_o
);

	logic [ADR_W-1:0] ptr_adr;
	logic [ADR_W-1:0] eff_adr;
	logic [ADR_W-1:0] stack_adr;
	logic [ADR_W-1:0] pop_adr;
	logic [CNT_W-1:0] push_cnt;
	logic             issue;
	logic             hz_fwd;
	// Merged memory write, from wr_i or a push
	logic             st_wr;
	logic [CNT_W-1:0] st_cnt;
	logic [ADR_W-1:0] slot_adr [HIST_DEPTH];
	logic [CNT_W-1:0] slot_cnt [HIST_DEPTH];

	ea_adr_calc i_adr_calc (
		.mode_i      (mode_i),
		.idx1_i      (idx1_i),
		.idx2_i      (idx2_i),
		.x_i         (x_i),
		.y_i         (y_i),
		.operand_i   (operand_i),
		.mem_dat_i   (mem_dat_i),
		.stack_adr_i (stack_adr),
		.ptr_adr_o   (ptr_adr),
		.eff_adr_o   (eff_adr)
	);

	ea_stack_ptr i_stack_ptr (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.issue_i     (issue),
		.stack_op_i  (stack_op_i),
		.x_i         (x_i),
		.stack_adr_o (stack_adr),
		.pop_adr_o   (pop_adr),
		.push_cnt_o  (push_cnt)
	);

	// Shifts every unstalled cycle so slot age tracks pipeline depth
	ea_wr_history i_wr_history (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.shift_i    (!stall_i),
		.wr_vld_i   (issue && st_wr),
		.wr_adr_i   (eff_adr),
		.wr_cnt_i   (st_cnt),
		.slot_adr_o (slot_adr),
		.slot_cnt_o (slot_cnt)
	);

	ea_hazard i_hazard (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.hold_i     (stall_i),
		.valid_i    (valid_i),
		.indir_i    (mode_i == MODE_INDIR),
		.rd_i       (rd_i),
		.ptr_adr_i  (ptr_adr),
		.eff_adr_i  (eff_adr),
		.slot_adr_i (slot_adr),
		.slot_cnt_i (slot_cnt),
		.wait_o     (wait_o),
		.fwd_o      (hz_fwd),
		.issue_o    (issue)
	);

	// Pop address on a stack read, else the pointer location
	assign mem_adr_o = (stack_op_i == SOP_POP || stack_op_i == SOP_PC_POP) ? pop_adr : ptr_adr;

	assign st_wr  = wr_i || (push_cnt != '0);
	assign st_cnt = (push_cnt != '0) ? push_cnt : wr_cnt_i;

	////////////////////////////////////////////////////////////////////////////
	// Stage output register
	////////////////////////////////////////////////////////////////////////////

	// Control flags, cleared on a bubble
	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			valid_o   <= 1'b0;
			wr_o      <= 1'b0;
			fwd_o     <= 1'b0;
			refill_o  <= 1'b0;
			jmp_adr_o <= PC_START;
		end
		else if (!stall_i)
		begin
			valid_o  <= issue;
			wr_o     <= issue && st_wr;
			fwd_o    <= issue && hz_fwd;
			refill_o <= issue && jmp_i;
			// Return address comes straight off the stack on PC pop
			if (issue)
				jmp_adr_o <= (stack_op_i == SOP_PC_POP) ? mem_dat_i : eff_adr;
		end
	end

	// Payload, qualified by valid_o
	always_ff @(posedge clk_i)
	begin
		if (!stall_i && issue)
		begin
			eff_adr_o <= eff_adr;
			wr_cnt_o  <= st_cnt;
			// Return address skips the two-byte call operand
			dat_o     <= (stack_op_i == SOP_PC_PUSH) ? pc_i + ADR_W'(2) : operand_i;
		end
	end

endmodule

// File: tb_ea_model.svh
// Model state with slot 0 as the newest write
logic [BYTE_W-1:0] m_sp;
logic [ADR_W-1:0]  m_hadr [HIST_DEPTH];
logic [CNT_W-1:0]  m_hcnt [HIST_DEPTH];
logic [WAIT_W-1:0] m_cnt;

// Results for the instruction now in front of the stage
logic [ADR_W-1:0]  x_mem_adr;
logic [ADR_W-1:0]  x_eff;
logic [ADR_W-1:0]  x_dat;
logic [ADR_W-1:0]  x_jmp;
logic              x_wr;
logic [CNT_W-1:0]  x_wcnt;
logic              x_fwd;
logic [WAIT_W-1:0] x_wait;
logic              x_issue;
logic [BYTE_W-1:0] x_sp_next;

// Registered outputs expected after the last edge
logic              e_valid;
logic              e_wr;
logic              e_fwd;
logic              e_refill;
logic [ADR_W-1:0]  e_jmp;
logic [ADR_W-1:0]  e_eff;
logic [ADR_W-1:0]  e_dat;
logic [CNT_W-1:0]  e_wcnt;

function automatic logic [ADR_W-1:0] index_val(
	input idx_sel_e          sel,
	input logic [BYTE_W-1:0] x,
	input logic [BYTE_W-1:0] y
);
	if (sel == IDX_X)
		return ADR_W'(x);
	if (sel == IDX_Y)
		return ADR_W'(y);
	return '0;
endfunction

// Byte by byte compare of a read span against a write span
function automatic logic overlaps(
	input logic [ADR_W-1:0] ra,
	input int               rn,
	input logic [ADR_W-1:0] wa,
	input logic [CNT_W-1:0] wn
);
	logic hit;
	hit = 1'b0;
	for (int i = 0; i < rn; i++)
	begin
		for (int j = 0; j < int'(wn); j++)
		begin
			if (ADR_W'(ra + ADR_W'(i)) == ADR_W'(wa + ADR_W'(j)))
				hit = 1'b1;
		end
	end
	return hit;
endfunction

function automatic void ea_expect(
	input logic              vld,
	input adr_mode_e         mode,
	input idx_sel_e          i1,
	input idx_sel_e          i2,
	input stack_op_e         sop,
	input logic              wr,
	input logic [CNT_W-1:0]  wcnt,
	input logic              rd,
	input logic [BYTE_W-1:0] x,
	input logic [BYTE_W-1:0] y,
	input logic [ADR_W-1:0]  opnd,
	input logic [ADR_W-1:0]  pc
);
	logic [ADR_W-1:0]  ptr;
	logic [ADR_W-1:0]  pop_adr;
	logic [WAIT_W-1:0] hz;
	logic [WAIT_W-1:0] w;
	logic              is_pop;
	ptr     = opnd + index_val(i1, x, y);
	pop_adr = {STACK_PAGE, m_sp + 8'd1};
	is_pop  = (sop == SOP_POP) || (sop == SOP_PC_POP);
	x_mem_adr = is_pop ? pop_adr : ptr;
	case (mode)
		// Pointer word read at ptr plus the second index
		MODE_INDIR: x_eff = mem[ptr] + index_val(i2, x, y);
		MODE_STACK:
		begin
			if (sop == SOP_PC_PUSH)
				x_eff = {STACK_PAGE, m_sp - 8'd1};
			else if (is_pop)
				x_eff = pop_adr;
			else
				x_eff = {STACK_PAGE, m_sp};
		end
		default: x_eff = ptr;
	endcase
	x_dat  = (sop == SOP_PC_PUSH) ? pc + 16'd2 : opnd;
	x_jmp  = (sop == SOP_PC_POP) ? mem[pop_adr] : x_eff;
	x_wr   = wr || (sop == SOP_PUSH) || (sop == SOP_PC_PUSH);
	x_wcnt = (sop == SOP_PUSH) ? 2'd1 : (sop == SOP_PC_PUSH) ? 2'd2 : wcnt;
	hz    = '0;
	x_fwd = 1'b0;
	for (int k = 0; k < HIST_DEPTH; k++)
	begin
		// Slot number k+1 waits 4 minus its number
		w = WAIT_W'(4 - (k + 1));
		if (mode == MODE_INDIR && overlaps(ptr, 2, m_hadr[k], m_hcnt[k]) && w > hz)
			hz = w;
		if (rd && overlaps(x_eff, 1, m_hadr[k], m_hcnt[k]))
		begin
			if (k == 0)
				x_fwd = 1'b1;
			else if (w > hz)
				hz = w;
		end
	end
	x_fwd   = x_fwd && vld;
	x_wait  = (m_cnt != '0) ? m_cnt : (vld ? hz : '0);
	x_issue = vld && (m_cnt == '0) && (hz == '0);
	case (sop)
		SOP_PUSH:    x_sp_next = m_sp - 8'd1;
		SOP_PC_PUSH: x_sp_next = m_sp - 8'd2;
		SOP_POP:     x_sp_next = m_sp + 8'd1;
		SOP_PC_POP:  x_sp_next = m_sp + 8'd2;
		SOP_LOAD_X:  x_sp_next = x;
		default:     x_sp_next = m_sp;
	endcase
endfunction

// One unstalled clock edge following ea_expect for the same cycle
task automatic model_advance(input logic jmp);
	for (int k = HIST_DEPTH - 1; k > 0; k--)
	begin
		m_hadr[k] = m_hadr[k-1];
		m_hcnt[k] = m_hcnt[k-1];
	end
	m_hadr[0] = x_eff;
	m_hcnt[0] = (x_issue && x_wr) ? x_wcnt : '0;
	if (m_cnt != '0)
		m_cnt = m_cnt - 2'd1;
	else if (x_wait != '0)
		m_cnt = x_wait - 2'd1;
	e_valid  = x_issue;
	e_wr     = x_issue && x_wr;
	e_fwd    = x_issue && x_fwd;
	e_refill = x_issue && jmp;
	if (x_issue)
	begin
		m_sp   = x_sp_next;
		e_eff  = x_eff;
		e_dat  = x_dat;
		e_wcnt = x_wcnt;
		e_jmp  = x_jmp;
	end
endtask

task automatic model_reset();
	m_sp  = SP_START;
	m_cnt = '0;
	for (int k = 0; k < HIST_DEPTH; k++)
	begin
		m_hadr[k] = '0;
		m_hcnt[k] = '0;
	end
	e_valid  = 1'b0;
	e_wr     = 1'b0;
	e_fwd    = 1'b0;
	e_refill = 1'b0;
	e_jmp    = PC_START;
endtask

// File: tb_ea_stage.sv
`timescale 1ns/1ns

module tb_ea_stage
	import ea_cfg_pkg::*;
	import ea_isa_pkg::*;
();

	// Instruction counts per test group
	localparam int N_DIR     = 12;
	localparam int N_IND     = 8;
	localparam int N_RND     = 40;
	localparam int N_FIXED   = 15;
	localparam int N_INSTR   = N_DIR + N_IND + N_RND + N_FIXED;
	// Worst case one issue plus three bubbles each
	localparam int CYC_LIMIT = 4 * N_INSTR + 100;

	logic              clk_i = 1'b0;
	logic              rst_n_i;
	logic              stall_i;
	logic              valid_i;
	adr_mode_e         mode_i;
	idx_sel_e          idx1_i;
	idx_sel_e          idx2_i;
	stack_op_e         stack_op_i;
	logic              wr_i;
	logic [CNT_W-1:0]  wr_cnt_i;
	logic              rd_i;
	logic              jmp_i;
	logic [BYTE_W-1:0] x_i;
	logic [BYTE_W-1:0] y_i;
	logic [ADR_W-1:0]  operand_i;
	logic [ADR_W-1:0]  pc_i;
	logic [ADR_W-1:0]  mem_dat_i;
	logic [ADR_W-1:0]  mem_adr_o;
	logic [WAIT_W-1:0] wait_o;
	logic              valid_o;
	logic [ADR_W-1:0]  eff_adr_o;
	logic [ADR_W-1:0]  dat_o;
	logic              wr_o;
	logic [CNT_W-1:0]  wr_cnt_o;
	logic              fwd_o;
	logic              refill_o;
	logic [ADR_W-1:0]  jmp_adr_o;

	// Word memory answering in the same cycle
	logic [ADR_W-1:0] mem [2**ADR_W];
	int               cyc_cnt = 0;
	logic             e_known = 1'b0;

	`include "tb_ea_model.svh"

	assign mem_dat_i = mem[mem_adr_o];

	ea_stage i_ea_stage (.*);

	initial
	begin
		forever #5 clk_i = ~clk_i;
	end

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display(">>> FAIL");
			$fatal(1, "Mismatch on %s", what);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare mid-cycle when everything has settled
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk_i)
	begin
		// Registered outputs against the last edge's prediction
		if (e_known)
		begin
			check("valid_o", 32'(valid_o), 32'(e_valid));
			check("wr_o", 32'(wr_o), 32'(e_wr));
			check("fwd_o", 32'(fwd_o), 32'(e_fwd));
			check("refill_o", 32'(refill_o), 32'(e_refill));
			check("jmp_adr_o", 32'(jmp_adr_o), 32'(e_jmp));
			if (e_valid)
			begin
				check("eff_adr_o", 32'(eff_adr_o), 32'(e_eff));
				check("dat_o", 32'(dat_o), 32'(e_dat));
			end
			if (e_wr)
				check("wr_cnt_o", 32'(wr_cnt_o), 32'(e_wcnt));
		end
		if (!rst_n_i)
		begin
			model_reset();
		end
		else
		begin
			ea_expect(valid_i, mode_i, idx1_i, idx2_i, stack_op_i, wr_i, wr_cnt_i, rd_i,
				x_i, y_i, operand_i, pc_i);
			check("wait_o", 32'(wait_o), 32'(x_wait));
			check("mem_adr_o", 32'(mem_adr_o), 32'(x_mem_adr));
			// Stall freezes the model along with the stage
			if (!stall_i)
				model_advance(jmp_i);
		end
		e_known = 1'b1;
	end

	always @(posedge clk_i)
	begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt >= CYC_LIMIT)
		begin
			$display(">>> FAIL");
			$fatal(1, "Timeout, run still going after %0d cycles", CYC_LIMIT);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	function automatic idx_sel_e pick_idx(input logic [1:0] r);
		if (r == 2'd1)
			return IDX_X;
		if (r == 2'd2)
			return IDX_Y;
		return IDX_NONE;
	endfunction

	// Presents one instruction and holds it until the wait drains
	task automatic send(
		input adr_mode_e        mode,
		input idx_sel_e         i1,
		input idx_sel_e         i2,
		input stack_op_e        sop,
		input logic             wr,
		input logic [CNT_W-1:0] wcnt,
		input logic             rd,
		input logic             jmp,
		input logic [ADR_W-1:0] opnd
	);
		@(posedge clk_i);
		valid_i    <= 1'b1;
		mode_i     <= mode;
		idx1_i     <= i1;
		idx2_i     <= i2;
		stack_op_i <= sop;
		wr_i       <= wr;
		wr_cnt_i   <= wcnt;
		rd_i       <= rd;
		jmp_i      <= jmp;
		operand_i  <= opnd;
		x_i        <= 8'($urandom);
		y_i        <= 8'($urandom);
		pc_i       <= 16'($urandom);
		@(negedge clk_i);
		while (wait_o != '0)
		begin
			@(negedge clk_i);
		end
	endtask

	// n bubble cycles with n at least 1
	task automatic idle(input int n);
		@(posedge clk_i);
		valid_i <= 1'b0;
		repeat (n - 1) @(posedge clk_i);
	endtask

	task automatic stall_for(input int n);
		@(posedge clk_i);
		stall_i <= 1'b1;
		repeat (n) @(posedge clk_i);
		stall_i <= 1'b0;
	endtask

	initial
	begin
		int unsigned r;
		r = $urandom(32'h3640507e);
		// Fill scrambles every address bit
		for (int a = 0; a < 2**ADR_W; a++)
		begin
			mem[a] = ADR_W'(a * 40503) ^ 16'h5A5A;
		end
		rst_n_i    = 1'b0;
		stall_i    = 1'b0;
		valid_i    = 1'b0;
		mode_i     = MODE_DIR;
		idx1_i     = IDX_NONE;
		idx2_i     = IDX_NONE;
		stack_op_i = SOP_NONE;
		wr_i       = 1'b0;
		wr_cnt_i   = 2'd1;
		rd_i       = 1'b0;
		jmp_i      = 1'b0;
		x_i        = '0;
		y_i        = '0;
		operand_i  = '0;
		pc_i       = '0;
		repeat (8) @(posedge clk_i);
		rst_n_i <= 1'b1;

		// Direct and indexed
		for (int n = 0; n < N_DIR; n++)
		begin
			r = $urandom;
			send(MODE_DIR, pick_idx(r[1:0]), IDX_NONE, SOP_NONE, r[2], 2'(1 + r[3]), r[4],
				1'b0, 16'(r >> 16));
		end
		// Indirect through memory
		for (int n = 0; n < N_IND; n++)
		begin
			r = $urandom;
			send(MODE_INDIR, pick_idx(r[1:0]), pick_idx(r[3:2]), SOP_NONE, 1'b0, 2'd1, r[4],
				1'b0, 16'(r >> 16));
		end

		// Stack ops after loading SP from a random X
		send(MODE_DIR, IDX_NONE, IDX_NONE, SOP_LOAD_X, 1'b0, 2'd1, 1'b0, 1'b0, 16'h0000);
		send(MODE_STACK, IDX_NONE, IDX_NONE, SOP_PUSH, 1'b0, 2'd1, 1'b0, 1'b0, 16'h00A5);
		send(MODE_STACK, IDX_NONE, IDX_NONE, SOP_PC_PUSH, 1'b0, 2'd1, 1'b0, 1'b0, 16'h7000);
		send(MODE_STACK, IDX_NONE, IDX_NONE, SOP_PC_POP, 1'b0, 2'd1, 1'b1, 1'b1, 16'h0000);
		send(MODE_STACK, IDX_NONE, IDX_NONE, SOP_POP, 1'b0, 2'd1, 1'b1, 1'b0, 16'h0000);
		send(MODE_DIR, IDX_NONE, IDX_NONE, SOP_NONE, 1'b0, 2'd1, 1'b0, 1'b1, 16'h8123);

		// Read right behind a write gets forwarded
		send(MODE_DIR, IDX_NONE, IDX_NONE, SOP_NONE, 1'b1, 2'd2, 1'b0, 1'b0, 16'h4000);
		send(MODE_DIR, IDX_NONE, IDX_NONE, SOP_NONE, 1'b0, 2'd1, 1'b1, 1'b0, 16'h4001);
		// Write in the second slot costs two bubbles
		send(MODE_DIR, IDX_NONE, IDX_NONE, SOP_NONE, 1'b1, 2'd1, 1'b0, 1'b0, 16'h4100);
		idle(1);
		send(MODE_DIR, IDX_NONE, IDX_NONE, SOP_NONE, 1'b0, 2'd1, 1'b1, 1'b0, 16'h4100);
		// Write in the third slot costs one bubble
		send(MODE_DIR, IDX_NONE, IDX_NONE, SOP_NONE, 1'b1, 2'd3, 1'b0, 1'b0, 16'h4200);
		idle(2);
		send(MODE_DIR, IDX_NONE, IDX_NONE, SOP_NONE, 1'b0, 2'd1, 1'b1, 1'b0, 16'h4202);
		// Pointer word straddles the newest write
		send(MODE_DIR, IDX_NONE, IDX_NONE, SOP_NONE, 1'b1, 2'd1, 1'b0, 1'b0, 16'h4300);
		send(MODE_INDIR, IDX_NONE, IDX_NONE, SOP_NONE, 1'b0, 2'd1, 1'b0, 1'b0, 16'h42FF);

		// Mixed traffic packed into a small window
		for (int n = 0; n < N_RND; n++)
		begin
			r = $urandom;
			send(r[4] ? MODE_INDIR : MODE_DIR, pick_idx(r[6:5]), pick_idx(r[8:7]), SOP_NONE,
				r[9], 2'(1 + r[11:10] % 3), r[12], r[13], 16'h5000 + 16'(r[19:16]));
		end

		// Outputs hold while stalled
		send(MODE_DIR, IDX_Y, IDX_NONE, SOP_NONE, 1'b1, 2'd2, 1'b0, 1'b1, 16'h6000);
		stall_for(5);
		idle(3);

		$display(">>> PASS");
		$finish;
	end

endmodule

// File: sim.f
+incdir+.
ea_cfg_pkg.sv
ea_isa_pkg.sv
ea_adr_calc.sv
ea_stack_ptr.sv
ea_wr_history.sv
ea_hazard.sv
ea_stage.sv
tb_ea_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the EA stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_ea_stage -f sim.f
out="$(./obj_dir/Vtb_ea_stage 2>&1 || true)"
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx '>>> PASS'
then
	exit 0
fi
exit 1
